// File: source/uart_pkg.sv
package uart_pkg;

	// Serial bit period in clock cycles.
	localparam int CLOCKS_PER_BIT = 16;
	localparam int BIT_CNT_W = $clog2(CLOCKS_PER_BIT);

	// Entries per byte queue.
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	// Register addresses.
	localparam logic [1:0] ADDR_DATA = 2'd0;
	localparam logic [1:0] ADDR_STATUS = 2'd1;

	typedef logic [7:0] byte_t;

	// Received byte in bits 7:0, framing error in bit 8.
	typedef struct packed {
		logic  frame_error;
		byte_t data;
	} rx_entry_t;

	// Bit 0 upward: rx_empty, rx_full, tx_empty, tx_full.
	typedef struct packed {
		logic tx_full;
		logic tx_empty;
		logic rx_full;
		logic rx_empty;
	} status_t;

endpackage

// File: source/fifo_if.sv
`timescale 1ns/10ps

interface fifo_if #(
	parameter type payload_t = uart_pkg::byte_t
) ();

	logic     push;
	payload_t wdata;
	logic     full;

	logic     pop;
	payload_t rdata;
	logic     empty;

	// Producer and consumer views.
	modport writer (output push, output wdata, input full, input empty);
	modport reader (output pop, input rdata, input empty, input full);

	// The queue's own view of the same signals.
	modport fifo_in (input push, input wdata, output full);
	modport fifo_out (input pop, output rdata, output empty);

endinterface

// File: source/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter type payload_t = uart_pkg::byte_t
) (
	input logic      i_clock,
	input logic      i_reset,
	fifo_if.fifo_in  wr,
	fifo_if.fifo_out rd
);
	import uart_pkg::*;

	payload_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		// Wrap at the last entry.
		if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_push = wr.push && !wr.full;
	assign do_pop = rd.pop && !rd.empty;

	assign wr.full = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign rd.empty = (count == '0);

	// Head entry falls through to the reader.
	assign rd.rdata = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			mem[wr_ptr] <= wr.wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: source/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver (
	input logic    i_clock,
	input logic    i_reset,
	input logic    i_uart_rx,
	fifo_if.writer rx_q
);
	import uart_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [2:0] bit_idx;
	byte_t shift;

	// Two-stage synchronizer, plus the previous value for edge detection.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= i_uart_rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	// Entry is captured at the stop sample.
	always_ff @(posedge i_clock) begin
		if (state == ST_STOP && bit_cnt == '0) begin
			rx_q.wdata <= '{frame_error: !rx_sync, data: shift};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			shift <= '0;
			rx_q.push <= 1'b0;
		end else begin
			rx_q.push <= 1'b0;
			if (state != ST_IDLE && bit_cnt != '0) begin
				bit_cnt <= bit_cnt - 1'b1;
			end else begin
				case (state)
					ST_IDLE: begin
						// Falling edge of a start bit; wait half a bit.
						if (!rx_sync && rx_last) begin
							state <= ST_START;
							bit_cnt <= BIT_CNT_W'(CLOCKS_PER_BIT / 2 - 1);
						end
					end
					ST_START: begin
						if (rx_sync) begin
							// Glitch, not a start bit.
							state <= ST_IDLE;
						end else begin
							state <= ST_DATA;
							bit_idx <= '0;
							bit_cnt <= BIT_CNT_W'(CLOCKS_PER_BIT - 1);
						end
					end
					ST_DATA: begin
						shift <= {rx_sync, shift[7:1]};
						bit_cnt <= BIT_CNT_W'(CLOCKS_PER_BIT - 1);
						if (bit_idx == 3'd7) begin
							state <= ST_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
					ST_STOP: begin
						// Frames arriving at a full queue are lost.
						rx_q.push <= !rx_q.full;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

endmodule

// File: source/uart_transmitter.sv
`timescale 1ns/10ps

module uart_transmitter (
	input logic    i_clock,
	input logic    i_reset,
	fifo_if.reader tx_q,
	output logic   o_uart_tx
);
	import uart_pkg::*;

	logic busy;
	logic [9:0] shreg;
	logic [3:0] bits_left;
	logic [BIT_CNT_W-1:0] bit_cnt;

	// Take the next byte as soon as the line is free.
	assign tx_q.pop = !busy && !tx_q.empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			shreg <= '1;
			bits_left <= '0;
			bit_cnt <= '0;
			o_uart_tx <= 1'b1;
		end else if (!busy) begin
			if (tx_q.pop) begin
				// Stop, data LSB first, start.
				shreg <= {1'b1, tx_q.rdata, 1'b0};
				o_uart_tx <= 1'b0;
				bits_left <= 4'd9;
				bit_cnt <= BIT_CNT_W'(CLOCKS_PER_BIT - 1);
				busy <= 1'b1;
			end
		end else if (bit_cnt != '0) begin
			bit_cnt <= bit_cnt - 1'b1;
		end else if (bits_left == '0) begin
			// Stop bit done.
			busy <= 1'b0;
			o_uart_tx <= 1'b1;
		end else begin
			shreg <= {1'b1, shreg[9:1]};
			o_uart_tx <= shreg[1];
			bits_left <= bits_left - 1'b1;
			bit_cnt <= BIT_CNT_W'(CLOCKS_PER_BIT - 1);
		end
	end

endmodule

// File: source/uart_wb_regs.sv
`timescale 1ns/10ps

module uart_wb_regs (
	input logic         i_clock,
	input logic         i_reset,
	input logic         i_wb_cyc,
	input logic         i_wb_stb,
	input logic         i_wb_we,
	input logic [1:0]   i_wb_adr,
	input logic [31:0]  i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	fifo_if.reader      rx_q,
	fifo_if.writer      tx_q
);
	import uart_pkg::*;

	logic access;
	logic data_sel;
	status_t status;
	logic [31:0] rd_value;

	// New transfer: strobe seen while ack is still low.
	assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign data_sel = (i_wb_adr == ADDR_DATA);

	assign status.rx_empty = rx_q.empty;
	assign status.rx_full = rx_q.full;
	assign status.tx_empty = tx_q.empty;
	assign status.tx_full = tx_q.full;

	// Queue side effects only on the acknowledging edge.
	assign rx_q.pop = access && !i_wb_we && data_sel && !rx_q.empty;
	assign tx_q.push = access && i_wb_we && data_sel && !tx_q.full;
	assign tx_q.wdata = i_wb_dat[7:0];

	always_comb begin
		rd_value = '0;
		if (!i_wb_we) begin
			case (i_wb_adr)
				ADDR_DATA: begin
					// Empty queue reads as zero.
					if (!rx_q.empty) begin
						rd_value = {23'b0, rx_q.rdata};
					end
				end
				ADDR_STATUS: rd_value = {28'b0, status};
				default: rd_value = '0;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_ack <= 1'b0;
			o_wb_dat <= '0;
		end else begin
			o_wb_ack <= access;
			if (access) begin
				o_wb_dat <= rd_value;
			end
		end
	end

endmodule

// File: source/uart_peripheral.sv
`timescale 1ns/10ps

module uart_peripheral (
	input logic         i_clock,
	input logic         i_reset,
	input logic         i_wb_cyc,
	input logic         i_wb_stb,
	input logic         i_wb_we,
	input logic [1:0]   i_wb_adr,
	input logic [31:0]  i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	input logic         i_uart_rx,
	output logic        o_uart_tx
);
	import uart_pkg::*;

	// Receive path queue and transmit path queue.
	fifo_if #(.payload_t(rx_entry_t)) rx_q ();
	fifo_if #(.payload_t(byte_t)) tx_q ();

	sync_fifo #(
		.payload_t(rx_entry_t)
	) u_rx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.wr(rx_q),
		.rd(rx_q)
	);

	sync_fifo #(
		.payload_t(byte_t)
	) u_tx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.wr(tx_q),
		.rd(tx_q)
	);

	uart_receiver u_receiver (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_uart_rx(i_uart_rx),
		.rx_q(rx_q)
	);

	uart_transmitter u_transmitter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.tx_q(tx_q),
		.o_uart_tx(o_uart_tx)
	);

	uart_wb_regs u_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.rx_q(rx_q),
		.tx_q(tx_q)
	);

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 4 ns period.
	initial begin
		o_clock = 1'b0;
		forever #2 o_clock = ~o_clock;
	end

	// Reset held for three rising edges.
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// File: tests/uart_sva.sv
`timescale 1ns/10ps

module uart_sva (
	input logic i_clock,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_rx_pop,
	input logic i_rx_empty,
	input logic i_tx_push,
	input logic i_tx_full
);

	// Ack is a single-cycle pulse.
	ack_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_wb_ack |=> !i_wb_ack)
		else $error("o_wb_ack stayed high for more than one cycle");

	// Ack only answers a strobe.
	ack_after_strobe: assert property (@(posedge i_clock) disable iff (i_reset)
		i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
		else $error("o_wb_ack rose without cyc and stb in the previous cycle");

	rx_pop_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		i_rx_pop |-> !i_rx_empty)
		else $error("receive FIFO popped while empty");

	tx_push_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		i_tx_push |-> !i_tx_full)
		else $error("transmit FIFO pushed while full");

endmodule

bind uart_wb_regs uart_sva u_sva (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_wb_cyc(i_wb_cyc),
	.i_wb_stb(i_wb_stb),
	.i_wb_ack(o_wb_ack),
	.i_rx_pop(rx_q.pop),
	.i_rx_empty(rx_q.empty),
	.i_tx_push(tx_q.push),
	.i_tx_full(tx_q.full)
);

// File: tests/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;
	import uart_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int GAP_MAX = 20;
	localparam int MARGIN_BITS = 40;

	logic i_clock;
	logic i_reset;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [1:0] i_wb_adr;
	logic [31:0] i_wb_dat;
	logic [31:0] o_wb_dat;
	logic o_wb_ack;
	logic i_uart_rx;
	logic o_uart_tx;

	// Op in bits 15:12, byte or expected value in bits 11:0.
	logic [15:0] golden [MAX_OPS];
	byte_t tx_seen [$];
	byte_t tx_expect [$];
	int n_ops;
	int pass_count;
	int fail_count;

	tb_clock_gen u_clock (
		.o_clock(i_clock),
		.o_reset(i_reset)
	);

	uart_peripheral u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.i_uart_rx(i_uart_rx),
		.o_uart_tx(o_uart_tx)
	);

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge i_clock);
	endtask

	task automatic report_result(input string name, input bit ok, input string detail);
		if (ok) begin
			$display("PASS %s", name);
			pass_count++;
		end else begin
			$display("MISMATCH %s %s", name, detail);
			fail_count++;
		end
	endtask

	task automatic check_entry(input string name, input rx_entry_t expected,
		input rx_entry_t actual);
		report_result(name, actual === expected,
			$sformatf("expected %h actual %h", expected, actual));
	endtask

	task automatic check_status(input string name, input status_t expected,
		input status_t actual);
		report_result(name, actual === expected,
			$sformatf("expected %h actual %h", expected, actual));
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		report_result(name, actual === expected,
			$sformatf("expected %h actual %h", expected, actual));
	endtask

	task automatic note_failure(input string text);
		$display("%s", text);
		fail_count++;
	endtask

	// Start bit, eight data bits LSB first, then the given stop bit.
	task automatic send_frame(input byte_t value, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			i_uart_rx <= frame[i];
			wait_cycles(CLOCKS_PER_BIT);
		end
		i_uart_rx <= 1'b1;
	endtask

	// One classic cycle; strobe held until ack is seen.
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= we;
		i_wb_adr <= adr;
		i_wb_dat <= wdata;
		@(posedge i_clock);
		while (o_wb_ack !== 1'b1) begin
			@(posedge i_clock);
		end
		rdata = o_wb_dat;
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		i_wb_we <= 1'b0;
	endtask

	// Compare everything written so far with what left on the line.
	task automatic drain_tx(input string name);
		int idx;
		while (tx_seen.size() < tx_expect.size()) begin
			@(posedge i_clock);
		end
		// Room for one more frame if a byte was not dropped.
		wait_cycles(12 * CLOCKS_PER_BIT);
		idx = 0;
		while (tx_expect.size() > 0) begin
			check_byte($sformatf("%s_byte%0d", name, idx), tx_expect.pop_front(),
				tx_seen.pop_front());
			idx++;
		end
		if (tx_seen.size() != 0) begin
			note_failure($sformatf("%s: %0d extra bytes appeared on o_uart_tx", name,
				tx_seen.size()));
			tx_seen.delete();
		end else begin
			report_result($sformatf("%s_no_extra", name), 1'b1, "");
		end
	endtask

	// Serial monitor samples each bit at its middle.
	initial begin
		byte_t value;
		logic start_bit;
		logic stop_bit;
		forever begin
			@(posedge i_clock);
			if (!i_reset && o_uart_tx === 1'b0) begin
				wait_cycles(CLOCKS_PER_BIT / 2 - 1);
				start_bit = o_uart_tx;
				for (int i = 0; i < 8; i++) begin
					wait_cycles(CLOCKS_PER_BIT);
					value[i] = o_uart_tx;
				end
				wait_cycles(CLOCKS_PER_BIT);
				stop_bit = o_uart_tx;
				if (start_bit !== 1'b0 || stop_bit !== 1'b1) begin
					note_failure($sformatf("Badly framed byte %h on o_uart_tx", value));
				end
				tx_seen.push_back(value);
			end
		end
	end

	initial begin
		logic [3:0] op;
		logic [11:0] value;
		logic [31:0] rdata;
		string name;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_uart_rx = 1'b1;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'h568eda48));
		foreach (golden[i]) begin
			golden[i] = '0;
		end
		$readmemh("tests/uart_golden.txt", golden);
		n_ops = 0;
		while (n_ops < MAX_OPS && golden[n_ops][15:12] != 4'h0) begin
			n_ops++;
		end
		fork
			begin
				wait_cycles((n_ops * 12 + MARGIN_BITS) * CLOCKS_PER_BIT);
				$display("Timeout: the tests did not finish in the allowed time");
				$display("Verification failed");
				$finish;
			end
		join_none
		@(posedge i_clock);
		while (i_reset) begin
			@(posedge i_clock);
		end
		report_result("reset_tx_idle", o_uart_tx === 1'b1,
			$sformatf("expected 1 actual %b", o_uart_tx));
		for (int k = 0; k < n_ops; k++) begin
			op = golden[k][15:12];
			value = golden[k][11:0];
			case (op)
				4'h1: send_frame(value[7:0], 1'b1);
				4'h2: send_frame(value[7:0], 1'b0);
				4'h3: begin
					name = $sformatf("read_step%0d", k + 1);
					bus_cycle(1'b0, ADDR_DATA, '0, rdata);
					check_entry(name, rx_entry_t'(value[8:0]), rx_entry_t'(rdata[8:0]));
					if (rdata[31:9] !== '0) begin
						note_failure($sformatf("%s: upper data bits are not zero", name));
					end
				end
				4'h4: begin
					name = $sformatf("status_step%0d", k + 1);
					bus_cycle(1'b0, ADDR_STATUS, '0, rdata);
					check_status(name, status_t'(value[3:0]), status_t'(rdata[3:0]));
					if (rdata[31:4] !== '0) begin
						note_failure($sformatf("%s: upper status bits are not zero", name));
					end
				end
				4'h5: begin
					bus_cycle(1'b1, ADDR_DATA, {24'h0, value[7:0]}, rdata);
					tx_expect.push_back(value[7:0]);
				end
				4'h6: bus_cycle(1'b1, ADDR_DATA, {24'h0, value[7:0]}, rdata);
				4'h7: drain_tx($sformatf("serial_step%0d", k + 1));
				default: note_failure($sformatf("Unknown operation %h in the golden file", op));
			endcase
			wait_cycles($urandom_range(GAP_MAX, 0));
		end
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: tests/uart_golden.txt
// Each line: op digit then three value digits, all hex.
// Ops: 1 RX, 2 RXBAD, 3 RD expected, 4 ST expected, 5 TX, 6 TX dropped, 7 check serial output.
4005 // ST after reset: rx_empty, tx_empty
1041 // RX
1042 // RX
3041 // RD
3042 // RD
3000 // RD of empty FIFO
2055 // RXBAD
3155 // RD with frame_error
1010 // RX
1011 // RX
1012 // RX
1013 // RX
1014 // RX into full FIFO, lost
4006 // ST rx_full, tx_empty
3010 // RD
3011 // RD
3012 // RD
3013 // RD
4005 // ST empty again
50a5 // TX
503c // TX
7000 // check serial output
5001 // TX, moves to transmitter
5002 // TX
5003 // TX
5004 // TX
5005 // TX, FIFO now full
6006 // TX dropped
4009 // ST tx_full, rx_empty
7000 // check serial output

// File: sim.f
source/uart_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/uart_wb_regs.sv
source/uart_peripheral.sv
tests/tb_clock_gen.sv
tests/uart_sva.sv
tests/uart_tb.sv
